// ==== sources.f ====
verilog/soc_interconnect_pkg.sv
verilog/tcdm_addr_decoder.sv
verilog/tcdm_rr_arbiter.sv
verilog/tcdm_xbar.sv
verilog/tcdm_to_apb.sv
verilog/soc_interconnect.sv
tb/soc_interconnect_checker.sv
tb/soc_interconnect_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module soc_interconnect_tb > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vsoc_interconnect_tb > sim.log 2>&1 ; cat sim.log

grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb/soc_interconnect_golden.txt ====
// test master rw(1=read) addr wdata target target_addr rdata r_opc
// target: 0/1 L2 bank, 2 private, 3 boot ROM, 4 APB, 5 error
1 0 0 1c010000 11112222 0 00000000 00000000 0
1 1 1 1c010000 00000000 0 00000000 11112222 0
1 0 0 1c010004 33334444 1 00000000 00000000 0
1 2 1 1c010004 00000000 1 00000000 33334444 0
1 2 0 1c000100 aaaa5555 2 1c000100 00000000 0
1 0 1 1c000100 00000000 2 1c000100 aaaa5555 0
1 1 1 1a000010 00000000 3 1a000010 cafe0010 0
1 0 0 1a000010 deadbeef 3 1a000010 00000000 0
1 2 1 1a000010 00000000 3 1a000010 cafe0010 0
2 1 0 1c010008 00000008 0 00000004 00000000 0
2 1 0 1c01000c 0000000c 1 00000004 00000000 0
2 1 0 1c010010 00000010 0 00000008 00000000 0
2 0 1 1c010008 00000000 0 00000004 00000008 0
2 0 1 1c01000c 00000000 1 00000004 0000000c 0
2 0 1 1c010010 00000000 0 00000008 00000010 0
3 0 0 00000200 0badf00d 2 1c000200 00000000 0
3 0 1 00000200 00000000 2 1c000200 0badf00d 0
3 1 1 1c000200 00000000 2 1c000200 0badf00d 0
3 2 1 00000200 00000000 5 00000000 00000000 1
4 1 1 30000000 00000000 5 00000000 00000000 1
4 0 0 1c020000 12121212 5 00000000 00000000 1
5 0 0 1a100004 12345678 4 1a100004 00000000 0
5 2 1 1a100004 00000000 4 1a100004 12345678 0
5 1 0 1a100040 87654321 4 1a100040 00000000 0
5 0 1 1a100040 00000000 4 1a100040 87654321 0
5 2 1 1a100f00 00000000 4 1a100f00 00000000 1
5 0 0 1a100f04 55555555 4 1a100f04 00000000 1
6 0 1 1c010000 00000000 0 00000000 11112222 0
6 1 1 1c010008 00000000 0 00000004 00000008 0
6 2 1 1c010010 00000000 0 00000008 00000010 0
ffffffff

// ==== tb/soc_interconnect_tb.sv ====
// SoC interconnect testbench
`timescale 1ns/1ps

module soc_interconnect_tb;
    import soc_interconnect_pkg::*;

    localparam int COLS            = 9;
    localparam int GOLDEN_WORDS    = 320;
    localparam int GNT_TIMEOUT     = 40;
    localparam int CONTENTION_TEST = 6;
    // Target code when no port saw the request
    localparam int NO_PORT         = 5;

    logic                              clk_i;
    logic                              rst_i;
    tcdm_req_t [NR_MASTERS-1:0]        master_req;
    tcdm_rsp_t [NR_MASTERS-1:0]        master_rsp;
    tcdm_rsp_t [NR_L2_BANKS-1:0]       l2_rsp;
    tcdm_rsp_t                         private_rsp;
    tcdm_rsp_t                         rom_rsp;
    apb_rsp_t                          apb_rsp;
    tcdm_req_t [NR_L2_BANKS-1:0]       l2_req;
    tcdm_req_t                         private_req;
    tcdm_req_t                         rom_req;
    apb_req_t                          apb_req;

    // Golden columns are test master rw addr wdata target target_addr rdata r_opc
    logic [31:0] golden [0:GOLDEN_WORDS-1];
    logic [31:0] bank_mem [0:NR_L2_BANKS-1][0:8191];
    logic [31:0] private_mem [0:8191];
    logic [31:0] rom_mem [0:4095];
    logic [31:0] apb_mem [0:255];
    // Requests seen just before the accepting edge
    tcdm_req_t [NR_L2_BANKS-1:0] snap_l2;
    tcdm_req_t                   snap_private;
    tcdm_req_t                   snap_rom;
    int                          apb_delay;
    int                          seed = 26;
    int                          checks;
    int                          errors;
    int                          gnt_order [$];
    // Expected round-robin pointer per arbiter
    int                          ptr_model [0:5];

    soc_interconnect UUT (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .master_req_i  (master_req),
        .l2_rsp_i      (l2_rsp),
        .private_rsp_i (private_rsp),
        .rom_rsp_i     (rom_rsp),
        .apb_rsp_i     (apb_rsp),
        .master_rsp_o  (master_rsp),
        .l2_req_o      (l2_req),
        .private_req_o (private_req),
        .rom_req_o     (rom_req),
        .apb_req_o     (apb_req)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////
    // Target models driven on the falling edge
    ////////////////////////////////////////////////////////////
    always begin
        @(negedge clk_i);
        // Serve what was accepted at the last rising edge
        for (int b = 0; b < NR_L2_BANKS; b++) begin
            if (snap_l2[b].req && snap_l2[b].wen) begin
                l2_rsp[b].r_rdata = bank_mem[b][snap_l2[b].add[14:2]];
            end else if (snap_l2[b].req) begin
                bank_mem[b][snap_l2[b].add[14:2]] = snap_l2[b].wdata;
            end
        end
        if (snap_private.req && snap_private.wen) begin
            private_rsp.r_rdata = private_mem[snap_private.add[14:2]];
        end else if (snap_private.req) begin
            private_mem[snap_private.add[14:2]] = snap_private.wdata;
        end
        // ROM ignores writes
        if (snap_rom.req && snap_rom.wen) begin
            rom_rsp.r_rdata = rom_mem[snap_rom.add[13:2]];
        end
        // APB slave with a random wait of 0 to 3 cycles in access
        apb_rsp.pready = 1'b0;
        if (apb_req.psel && !apb_req.penable) begin
            apb_delay = $random(seed) & 32'h3;
        end else if (apb_req.psel && apb_req.penable && apb_delay == 0) begin
            apb_rsp.pready = 1'b1;
            // Slot 0xf00 and up reports a slave error
            if (apb_req.paddr[11:8] == 4'hf) begin
                apb_rsp.pslverr = 1'b1;
                apb_rsp.prdata  = '0;
            end else if (apb_req.pwrite) begin
                apb_rsp.pslverr = 1'b0;
                apb_mem[apb_req.paddr[9:2]] = apb_req.pwdata;
            end else begin
                apb_rsp.pslverr = 1'b0;
                apb_rsp.prdata  = apb_mem[apb_req.paddr[9:2]];
            end
        end else if (apb_req.psel && apb_req.penable) begin
            apb_delay = apb_delay - 1;
        end
        #25;
        snap_l2      = l2_req;
        snap_private = private_req;
        snap_rom     = rom_req;
    end

    ////////////////////////////////////////////////////////////
    // Checking helpers
    ////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("Mismatch %s: expected 0x%h, got 0x%h", name, exp, got);
        end
    endtask

    // Which target port carries the current request
    task automatic find_port(output int port, output logic [31:0] taddr);
        port  = NO_PORT;
        taddr = '0;
        if (l2_req[0].req) begin
            port  = 0;
            taddr = l2_req[0].add;
        end else if (l2_req[1].req) begin
            port  = 1;
            taddr = l2_req[1].add;
        end else if (private_req.req) begin
            port  = 2;
            taddr = private_req.add;
        end else if (rom_req.req) begin
            port  = 3;
            taddr = rom_req.add;
        end else if (apb_req.psel) begin
            port  = 4;
            taddr = apb_req.paddr;
        end
    endtask

    // One TCDM access from a golden line through to r_valid
    task automatic run_access(input int e, input bit in_group);
        int          m;
        logic        rd;
        int          tgt;
        int          cycles;
        bit          granted;
        int          port;
        logic [31:0] taddr;
        m   = golden[e*COLS+1];
        rd  = golden[e*COLS+2][0];
        tgt = golden[e*COLS+5];
        @(negedge clk_i);
        master_req[m].req   = 1'b1;
        master_req[m].wen   = rd;
        master_req[m].add   = golden[e*COLS+3];
        master_req[m].wdata = golden[e*COLS+4];
        master_req[m].be    = 4'hf;
        granted = 1'b0;
        cycles  = 0;
        while (!granted && cycles < GNT_TIMEOUT) begin
            #25;
            if (master_rsp[m].gnt) begin
                granted = 1'b1;
            end else begin
                cycles++;
                @(negedge clk_i);
            end
        end
        if (!granted) begin
            $display("Timeout: master %0d got no grant for address 0x%h", m, golden[e*COLS+3]);
            $display("Simulation failed");
            $finish;
        end else begin
            gnt_order.push_back(m);
            if (!in_group) begin
                find_port(port, taddr);
                check_value("target", tgt, port);
                if (tgt != NO_PORT) begin
                    check_value("target_addr", golden[e*COLS+6], taddr);
                end
                ptr_model[tgt] = (m + 1) % NR_MASTERS;
            end
            @(negedge clk_i);
            master_req[m] = '0;
            #25;
            checks++;
            if (!master_rsp[m].r_valid) begin
                errors++;
                $display("Master %0d saw no r_valid one cycle after its grant", m);
            end else begin
                check_value("r_opc", golden[e*COLS+8], master_rsp[m].r_opc);
                if (rd || golden[e*COLS+8][0]) begin
                    check_value("r_rdata", golden[e*COLS+7], master_rsp[m].r_rdata);
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int e;
        int t;
        int test_err;
        int p;
        rst_i       = 1'b1;
        master_req  = '0;
        l2_rsp      = '0;
        private_rsp = '0;
        rom_rsp     = '0;
        apb_rsp     = '0;
        apb_delay   = 0;
        checks      = 0;
        errors      = 0;
        for (int i = 0; i < 6; i++) begin
            ptr_model[i] = 0;
        end
        // All ones marks the end of the transaction list
        for (int i = 0; i < GOLDEN_WORDS; i++) begin
            golden[i] = 32'hffff_ffff;
        end
        $readmemh("tb/soc_interconnect_golden.txt", golden);
        // ROM contents come from the expected read data
        for (int i = 0; golden[i*COLS] != 32'hffff_ffff; i++) begin
            if (golden[i*COLS+5] == 3 && golden[i*COLS+2] == 1) begin
                rom_mem[golden[i*COLS+3][13:2]] = golden[i*COLS+7];
            end
        end
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        e = 0;
        while (golden[e*COLS] != 32'hffff_ffff) begin
            t        = golden[e*COLS];
            test_err = errors;
            if (t == CONTENTION_TEST) begin
                // All three masters on one bank at once
                gnt_order.delete();
                fork
                    run_access(e, 1'b1);
                    run_access(e + 1, 1'b1);
                    run_access(e + 2, 1'b1);
                join
                // One full round starting at p leaves the pointer at p again
                p = ptr_model[golden[e*COLS+5]];
                for (int k = 0; k < NR_MASTERS; k++) begin
                    check_value("grant_order", (p + k) % NR_MASTERS, gnt_order[k]);
                end
                e = e + 3;
            end else begin
                while (golden[e*COLS] == t) begin
                    run_access(e, 1'b0);
                    e++;
                end
            end
            $display("Test %0d finished with %0d errors", t, errors - test_err);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb/soc_interconnect_checker.sv ====
// Interconnect protocol assertions
`timescale 1ns/1ps

module soc_interconnect_checker (
    input logic                                                          clk_i,
    input logic                                                          rst_i,
    input soc_interconnect_pkg::tcdm_req_t [soc_interconnect_pkg::NR_MASTERS-1:0] master_req_i,
    input soc_interconnect_pkg::tcdm_rsp_t [soc_interconnect_pkg::NR_MASTERS-1:0] master_rsp_o,
    input soc_interconnect_pkg::apb_req_t                                apb_req_o,
    input soc_interconnect_pkg::apb_rsp_t                                apb_rsp_i
);
    import soc_interconnect_pkg::*;

    ////////////////////////////////////////////////////////////
    // TCDM side, one set per master
    ////////////////////////////////////////////////////////////
    for (genvar m = 0; m < NR_MASTERS; m++) begin : g_master
        // No grant without a pending request
        assert property (@(posedge clk_i) disable iff (rst_i)
            master_rsp_o[m].gnt |-> master_req_i[m].req)
            else $error("master %0d granted without a request", m);
        // Response exactly one cycle after the grant
        assert property (@(posedge clk_i) disable iff (rst_i)
            master_rsp_o[m].gnt |=> master_rsp_o[m].r_valid)
            else $error("master %0d missing r_valid after grant", m);
    end

    ////////////////////////////////////////////////////////////
    // APB phases
    ////////////////////////////////////////////////////////////
    // Access phase needs a setup cycle first
    assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(apb_req_o.penable) |-> $past(apb_req_o.psel && !apb_req_o.penable))
        else $error("penable raised without a setup cycle");

    // Setup always moves into access
    assert property (@(posedge clk_i) disable iff (rst_i)
        (apb_req_o.psel && !apb_req_o.penable) |=> (apb_req_o.psel && apb_req_o.penable))
        else $error("setup phase not followed by access");

    // Transfer held steady while the slave stalls
    assert property (@(posedge clk_i) disable iff (rst_i)
        (apb_req_o.psel && apb_req_o.penable && !apb_rsp_i.pready) |=>
        (apb_req_o.psel && apb_req_o.penable && $stable(apb_req_o.paddr)
            && $stable(apb_req_o.pwrite)))
        else $error("APB transfer changed before pready");

endmodule

bind soc_interconnect soc_interconnect_checker i_checker (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .master_req_i (master_req_i),
    .master_rsp_o (master_rsp_o),
    .apb_req_o    (apb_req_o),
    .apb_rsp_i    (apb_rsp_i)
);

// ==== verilog/soc_interconnect.sv ====
// SoC interconnect top level
`timescale 1ns/1ps

module soc_interconnect (
    input  logic                                                          clk_i,
    input  logic                                                          rst_i,
    input  soc_interconnect_pkg::tcdm_req_t [soc_interconnect_pkg::NR_MASTERS-1:0] master_req_i,
    // Memory targets only return r_rdata
    input  soc_interconnect_pkg::tcdm_rsp_t [soc_interconnect_pkg::NR_L2_BANKS-1:0] l2_rsp_i,
    input  soc_interconnect_pkg::tcdm_rsp_t                               private_rsp_i,
    input  soc_interconnect_pkg::tcdm_rsp_t                               rom_rsp_i,
    input  soc_interconnect_pkg::apb_rsp_t                                apb_rsp_i,
    output soc_interconnect_pkg::tcdm_rsp_t [soc_interconnect_pkg::NR_MASTERS-1:0] master_rsp_o,
    output soc_interconnect_pkg::tcdm_req_t [soc_interconnect_pkg::NR_L2_BANKS-1:0] l2_req_o,
    output soc_interconnect_pkg::tcdm_req_t                               private_req_o,
    output soc_interconnect_pkg::tcdm_req_t                               rom_req_o,
    output soc_interconnect_pkg::apb_req_t                                apb_req_o
);
    import soc_interconnect_pkg::*;

    logic [NR_L2_BANKS-1:0][DATA_WIDTH-1:0] l2_rdata;
    // Crossbar to bridge
    tcdm_req_t                              apb_tcdm_req;
    logic                                   apb_gnt;
    logic                                   apb_err;
    logic [DATA_WIDTH-1:0]                  apb_rdata;

    for (genvar b = 0; b < NR_L2_BANKS; b++) begin : g_l2_rdata
        assign l2_rdata[b] = l2_rsp_i[b].r_rdata;
    end

    tcdm_xbar i_xbar (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .master_req_i    (master_req_i),
        .l2_rdata_i      (l2_rdata),
        .private_rdata_i (private_rsp_i.r_rdata),
        .rom_rdata_i     (rom_rsp_i.r_rdata),
        .apb_gnt_i       (apb_gnt),
        .apb_err_i       (apb_err),
        .apb_rdata_i     (apb_rdata),
        .master_rsp_o    (master_rsp_o),
        .l2_req_o        (l2_req_o),
        .private_req_o   (private_req_o),
        .rom_req_o       (rom_req_o),
        .apb_req_o       (apb_tcdm_req)
    );

    tcdm_to_apb i_tcdm_to_apb (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .req_i     (apb_tcdm_req),
        .apb_rsp_i (apb_rsp_i),
        .apb_req_o (apb_req_o),
        .gnt_o     (apb_gnt),
        .err_o     (apb_err),
        .rdata_o   (apb_rdata)
    );

endmodule

// ==== verilog/tcdm_to_apb.sv ====
// TCDM to APB bridge
`timescale 1ns/1ps

module tcdm_to_apb (
    input  logic                                       clk_i,
    input  logic                                       rst_i,
    input  soc_interconnect_pkg::tcdm_req_t            req_i,
    input  soc_interconnect_pkg::apb_rsp_t             apb_rsp_i,
    output soc_interconnect_pkg::apb_req_t             apb_req_o,
    output logic                                       gnt_o,
    output logic                                       err_o,
    output logic [soc_interconnect_pkg::DATA_WIDTH-1:0] rdata_o
);
    import soc_interconnect_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } state_e;

    state_e                state_q;
    state_e                state_d;
    logic [ADDR_WIDTH-1:0] paddr_q;
    logic                  pwrite_q;
    logic [DATA_WIDTH-1:0] pwdata_q;

    ////////////////////////////////////////////////////////////
    // Phase FSM
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (req_i.req) state_d = SETUP;
            SETUP:   state_d = ACCESS;
            // Stay in access until the slave is ready
            ACCESS:  if (apb_rsp_i.pready) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Transfer ends, master grant in the same cycle
    assign gnt_o = (state_q == ACCESS) && apb_rsp_i.pready;

    // Request fields are frozen for the whole transfer
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && req_i.req) begin
            paddr_q  <= req_i.add;
            pwrite_q <= ~req_i.wen;
            pwdata_q <= req_i.wdata;
        end
    end

    // Slave response kept for the r_valid cycle
    always_ff @(posedge clk_i) begin
        if (gnt_o) begin
            rdata_o <= apb_rsp_i.prdata;
            err_o   <= apb_rsp_i.pslverr;
        end
    end

    always_comb begin
        apb_req_o.paddr   = paddr_q;
        apb_req_o.psel    = (state_q != IDLE);
        apb_req_o.penable = (state_q == ACCESS);
        apb_req_o.pwrite  = pwrite_q;
        apb_req_o.pwdata  = pwdata_q;
    end

endmodule

// ==== verilog/tcdm_xbar.sv ====
// TCDM crossbar
`timescale 1ns/1ps

module tcdm_xbar (
    input  logic                                                          clk_i,
    input  logic                                                          rst_i,
    input  soc_interconnect_pkg::tcdm_req_t [soc_interconnect_pkg::NR_MASTERS-1:0] master_req_i,
    input  logic [soc_interconnect_pkg::NR_L2_BANKS-1:0][soc_interconnect_pkg::DATA_WIDTH-1:0]
                                                                          l2_rdata_i,
    input  logic [soc_interconnect_pkg::DATA_WIDTH-1:0]                   private_rdata_i,
    input  logic [soc_interconnect_pkg::DATA_WIDTH-1:0]                   rom_rdata_i,
    input  logic                                                          apb_gnt_i,
    input  logic                                                          apb_err_i,
    input  logic [soc_interconnect_pkg::DATA_WIDTH-1:0]                   apb_rdata_i,
    output soc_interconnect_pkg::tcdm_rsp_t [soc_interconnect_pkg::NR_MASTERS-1:0] master_rsp_o,
    output soc_interconnect_pkg::tcdm_req_t [soc_interconnect_pkg::NR_L2_BANKS-1:0] l2_req_o,
    output soc_interconnect_pkg::tcdm_req_t                               private_req_o,
    output soc_interconnect_pkg::tcdm_req_t                               rom_req_o,
    output soc_interconnect_pkg::tcdm_req_t                               apb_req_o
);
    import soc_interconnect_pkg::*;

    tcdm_req_t   [NR_MASTERS-1:0]                 dec_req;
    target_idx_t [NR_MASTERS-1:0]                 dec_tgt;
    arb_idx_t    [NR_MASTERS-1:0]                 dec_arb;
    tcdm_req_t   [NR_ARBS-1:0][NR_MASTERS-1:0]    arb_in;
    tcdm_req_t   [NR_ARBS-1:0]                    arb_out;
    logic        [NR_ARBS-1:0]                    arb_ready;
    logic        [NR_ARBS-1:0][NR_MASTERS-1:0]    arb_gnt;
    logic        [NR_ARBS-1:0][NR_MASTERS-1:0]    arb_rvalid;
    logic        [NR_ARBS-1:0][DATA_WIDTH-1:0]    arb_rdata;
    logic        [NR_ARBS-1:0]                    arb_opc;
    logic        [NR_L2_BANKS-1:0][ADDR_WIDTH-1:0] bank_off;
    // Arbiter that granted each master, used for the return cycle
    arb_idx_t    [NR_MASTERS-1:0]                 rsp_sel_q;

    ////////////////////////////////////////////////////////////
    // Address decoding per master
    ////////////////////////////////////////////////////////////
    for (genvar m = 0; m < NR_MASTERS; m++) begin : g_dec
        tcdm_addr_decoder #(
            .ALIAS_EN (m == 0)
        ) i_dec (
            .req_i    (master_req_i[m]),
            .req_o    (dec_req[m]),
            .target_o (dec_tgt[m])
        );
        // Interleaved region splits on the bank bit
        assign dec_arb[m] = (dec_tgt[m] == TGT_L2) ?
                            arb_idx_t'(dec_req[m].add[L2_BANK_BIT]) : dec_tgt[m] + 3'd1;
    end

    // Each arbiter only sees requests aimed at it
    always_comb begin
        for (int a = 0; a < NR_ARBS; a++) begin
            for (int m = 0; m < NR_MASTERS; m++) begin
                arb_in[a][m]     = dec_req[m];
                arb_in[a][m].req = dec_req[m].req && (dec_arb[m] == arb_idx_t'(a));
            end
        end
    end

    // Only the APB path can stall
    always_comb begin
        arb_ready          = '1;
        arb_ready[ARB_APB] = apb_gnt_i;
    end

    for (genvar a = 0; a < NR_ARBS; a++) begin : g_arb
        tcdm_rr_arbiter i_arb (
            .clk_i       (clk_i),
            .rst_i       (rst_i),
            .req_i       (arb_in[a]),
            .ready_i     (arb_ready[a]),
            .req_o       (arb_out[a]),
            .gnt_o       (arb_gnt[a]),
            .rsp_valid_o (arb_rvalid[a])
        );
    end

    ////////////////////////////////////////////////////////////
    // Target ports
    ////////////////////////////////////////////////////////////
    for (genvar b = 0; b < NR_L2_BANKS; b++) begin : g_bank
        assign bank_off[b] = arb_out[b].add - L2_TCDM_START;
        // Region offset with the bank bit squeezed out
        always_comb begin
            l2_req_o[b]     = arb_out[b];
            l2_req_o[b].add = {1'b0, bank_off[b][ADDR_WIDTH-1:L2_BANK_BIT+1],
                               bank_off[b][L2_BANK_BIT-1:0]};
        end
    end

    assign private_req_o = arb_out[ARB_PRIVATE];
    assign rom_req_o     = arb_out[ARB_ROM];
    assign apb_req_o     = arb_out[ARB_APB];

    ////////////////////////////////////////////////////////////
    // Response path
    ////////////////////////////////////////////////////////////
    always_comb begin
        arb_rdata = '0;
        arb_opc   = '0;
        for (int b = 0; b < NR_L2_BANKS; b++) begin
            arb_rdata[b] = l2_rdata_i[b];
        end
        arb_rdata[ARB_PRIVATE] = private_rdata_i;
        arb_rdata[ARB_ROM]     = rom_rdata_i;
        arb_rdata[ARB_APB]     = apb_rdata_i;
        arb_opc[ARB_APB]       = apb_err_i;
        // Error target returns zero data with r_opc set
        arb_opc[ARB_ERROR]     = 1'b1;
    end

    always_comb begin
        for (int m = 0; m < NR_MASTERS; m++) begin
            master_rsp_o[m].gnt     = 1'b0;
            master_rsp_o[m].r_valid = 1'b0;
            for (int a = 0; a < NR_ARBS; a++) begin
                master_rsp_o[m].gnt     |= arb_gnt[a][m];
                master_rsp_o[m].r_valid |= arb_rvalid[a][m];
            end
            master_rsp_o[m].r_opc   = arb_opc[rsp_sel_q[m]];
            master_rsp_o[m].r_rdata = arb_rdata[rsp_sel_q[m]];
        end
    end

    always_ff @(posedge clk_i) begin
        for (int m = 0; m < NR_MASTERS; m++) begin
            if (master_rsp_o[m].gnt) begin
                rsp_sel_q[m] <= dec_arb[m];
            end
        end
    end

endmodule

// ==== verilog/tcdm_rr_arbiter.sv ====
// Round-robin TCDM arbiter
`timescale 1ns/1ps

module tcdm_rr_arbiter (
    input  logic                                                         clk_i,
    input  logic                                                         rst_i,
    // Requests already filtered to this target
    input  soc_interconnect_pkg::tcdm_req_t [soc_interconnect_pkg::NR_MASTERS-1:0] req_i,
    input  logic                                                         ready_i,
    output soc_interconnect_pkg::tcdm_req_t                              req_o,
    output logic [soc_interconnect_pkg::NR_MASTERS-1:0]                  gnt_o,
    output logic [soc_interconnect_pkg::NR_MASTERS-1:0]                  rsp_valid_o
);
    import soc_interconnect_pkg::*;

    logic [MASTER_IDX_WIDTH-1:0] ptr_q;
    logic [MASTER_IDX_WIDTH-1:0] winner;
    logic [MASTER_IDX_WIDTH-1:0] held_q;
    // Set while a slow target keeps the winner waiting
    logic                        hold_q;

    ////////////////////////////////////////////////////////////
    // Winner selection
    ////////////////////////////////////////////////////////////
    always_comb begin
        int idx;
        winner = ptr_q;
        // Walk backwards so the requester nearest the pointer is kept
        for (int k = NR_MASTERS - 1; k >= 0; k--) begin
            idx = int'(ptr_q) + k;
            if (idx >= NR_MASTERS) begin
                idx = idx - NR_MASTERS;
            end
            if (req_i[idx].req) begin
                winner = MASTER_IDX_WIDTH'(idx);
            end
        end
        // Locked choice holds until the stalled target is done
        if (hold_q) begin
            winner = held_q;
        end
    end

    assign req_o = req_i[winner];

    // Grant only when the target takes the request
    always_comb begin
        gnt_o = '0;
        if (req_o.req && ready_i) begin
            gnt_o[winner] = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pointer, lock and response select
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ptr_q       <= '0;
            hold_q      <= 1'b0;
            rsp_valid_o <= '0;
        end else begin
            // Response one cycle after the grant
            rsp_valid_o <= gnt_o;
            if (|gnt_o) begin
                hold_q <= 1'b0;
                // Next priority goes to the master after the winner
                if (winner == MASTER_IDX_WIDTH'(NR_MASTERS - 1)) begin
                    ptr_q <= '0;
                end else begin
                    ptr_q <= winner + MASTER_IDX_WIDTH'(1);
                end
            end else if (req_o.req) begin
                hold_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_o.req && !hold_q) begin
            held_q <= winner;
        end
    end

endmodule

// ==== verilog/tcdm_addr_decoder.sv ====
// TCDM address decoder
`timescale 1ns/1ps

module tcdm_addr_decoder #(
    // Prefix alias, only the fc_data port has it
    parameter bit ALIAS_EN = 1'b0
) (
    input  soc_interconnect_pkg::tcdm_req_t   req_i,
    output soc_interconnect_pkg::tcdm_req_t   req_o,
    output soc_interconnect_pkg::target_idx_t target_o
);
    import soc_interconnect_pkg::*;

    // Alias remap, then first matching rule wins
    always_comb begin
        logic found;
        req_o = req_i;
        if (ALIAS_EN && req_i.add[ADDR_WIDTH-1 -: PREFIX_WIDTH] == ALIAS_PREFIX_FROM) begin
            req_o.add[ADDR_WIDTH-1 -: PREFIX_WIDTH] = ALIAS_PREFIX_TO;
        end
        // No match ends at the error target
        target_o = TGT_ERROR;
        found    = 1'b0;
        for (int r = 0; r < NR_RULES; r++) begin
            if (!found && req_o.add >= ADDR_RULES[r].start_addr
                    && req_o.add <= ADDR_RULES[r].end_addr) begin
                target_o = ADDR_RULES[r].idx;
                found    = 1'b1;
            end
        end
    end

endmodule

// ==== verilog/soc_interconnect_pkg.sv ====
// SoC interconnect definitions
package soc_interconnect_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths and port counts
    ////////////////////////////////////////////////////////////
    localparam int ADDR_WIDTH       = 32;
    localparam int DATA_WIDTH       = 32;
    localparam int BE_WIDTH         = 4;
    localparam int PREFIX_WIDTH     = 12;
    // Masters: 0 fc_data, 1 fc_instr, 2 debug
    localparam int NR_MASTERS       = 3;
    localparam int MASTER_IDX_WIDTH = 2;
    // Targets: 0 interleaved L2, 1 private bank, 2 boot ROM, 3 APB, 4 error
    localparam int NR_TARGETS       = 5;
    localparam int NR_RULES         = 4;
    localparam int NR_L2_BANKS      = 2;
    // Word address bit that selects the L2 bank
    localparam int L2_BANK_BIT      = 2;

    typedef logic [2:0] target_idx_t;

    localparam target_idx_t TGT_L2      = 3'd0;
    localparam target_idx_t TGT_PRIVATE = 3'd1;
    localparam target_idx_t TGT_ROM     = 3'd2;
    localparam target_idx_t TGT_APB     = 3'd3;
    localparam target_idx_t TGT_ERROR   = 3'd4;

    // One arbiter per bank plus one per remaining target
    localparam int NR_ARBS       = NR_TARGETS + NR_L2_BANKS - 1;
    localparam int ARB_IDX_WIDTH = 3;
    typedef logic [ARB_IDX_WIDTH-1:0] arb_idx_t;

    localparam int ARB_PRIVATE = 2;
    localparam int ARB_ROM     = 3;
    localparam int ARB_APB     = 4;
    localparam int ARB_ERROR   = 5;

    ////////////////////////////////////////////////////////////
    // Memory map
    ////////////////////////////////////////////////////////////
    localparam logic [ADDR_WIDTH-1:0] L2_TCDM_START      = 32'h1c01_0000;
    localparam logic [ADDR_WIDTH-1:0] L2_TCDM_END        = 32'h1c01_ffff;
    localparam logic [ADDR_WIDTH-1:0] PRIVATE_BANK_START = 32'h1c00_0000;
    localparam logic [ADDR_WIDTH-1:0] PRIVATE_BANK_END   = 32'h1c00_7fff;
    localparam logic [ADDR_WIDTH-1:0] BOOT_ROM_START     = 32'h1a00_0000;
    localparam logic [ADDR_WIDTH-1:0] BOOT_ROM_END       = 32'h1a00_3fff;
    localparam logic [ADDR_WIDTH-1:0] PERIPHERALS_START  = 32'h1a10_0000;
    localparam logic [ADDR_WIDTH-1:0] PERIPHERALS_END    = 32'h1a1f_ffff;

    // Legacy fc_data alias, 0x000xxxxx is seen as 0x1c0xxxxx
    localparam logic [PREFIX_WIDTH-1:0] ALIAS_PREFIX_FROM = 12'h000;
    localparam logic [PREFIX_WIDTH-1:0] ALIAS_PREFIX_TO   = 12'h1c0;

    // Inclusive address range of one target
    typedef struct packed {
        target_idx_t           idx;
        logic [ADDR_WIDTH-1:0] start_addr;
        logic [ADDR_WIDTH-1:0] end_addr;
    } addr_rule_t;

    localparam addr_rule_t [NR_RULES-1:0] ADDR_RULES = '{
        '{idx: TGT_APB,     start_addr: PERIPHERALS_START,  end_addr: PERIPHERALS_END},
        '{idx: TGT_ROM,     start_addr: BOOT_ROM_START,     end_addr: BOOT_ROM_END},
        '{idx: TGT_PRIVATE, start_addr: PRIVATE_BANK_START, end_addr: PRIVATE_BANK_END},
        '{idx: TGT_L2,      start_addr: L2_TCDM_START,      end_addr: L2_TCDM_END}
    };

    ////////////////////////////////////////////////////////////
    // Bus structs
    ////////////////////////////////////////////////////////////
    // TCDM request, wen high means read
    typedef struct packed {
        logic                  req;
        logic                  wen;
        logic [ADDR_WIDTH-1:0] add;
        logic [DATA_WIDTH-1:0] wdata;
        logic [BE_WIDTH-1:0]   be;
    } tcdm_req_t;

    typedef struct packed {
        logic                  gnt;
        logic                  r_valid;
        logic                  r_opc;
        logic [DATA_WIDTH-1:0] r_rdata;
    } tcdm_rsp_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] paddr;
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [DATA_WIDTH-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

endpackage
